// File: lpif_online_sync.sv
//////////////////////////////////////////////////
// Online sync for both link directions
// Holds tx and rx online low until a programmable
// delay has elapsed after the raw online input
// rises. Drops one edge after the input drops
//////////////////////////////////////////////////

`default_nettype none

module lpif_online_sync
  import lpif_pkg::*;
(
  input  logic        clk_wr,
  input  logic        rst_n,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay
);

  // Index 0 is tx, index 1 is rx
  logic [1:0]       online_in;
  logic [1:0][15:0] delay_in;
  logic [1:0]       online_q;

  assign online_in = {rx_online, tx_online};
  // Tx uses the y delay, rx uses the x delay
  assign delay_in  = {delay_x_value, delay_y_value};

  //////////////////////////////////////////////////
  // One FSM and down counter per direction
  for (genvar i = 0; i < 2; i++) begin : g_dir
    sync_state_e state_q;
    logic [15:0] cnt_q;

    always_ff @(posedge clk_wr or negedge rst_n) begin
      if (!rst_n) begin
        state_q <= SYNC_IDLE;
        cnt_q   <= '0;
      end else if (!online_in[i]) begin
        // Input low aborts from any state
        state_q <= SYNC_IDLE;
      end else begin
        case (state_q)
          SYNC_IDLE: begin
            // Load delay on the first edge seeing online
            state_q <= SYNC_COUNT;
            cnt_q   <= delay_in[i];
          end
          SYNC_COUNT: begin
            if (cnt_q == '0) begin
              state_q <= SYNC_ONLINE;
            end else begin
              cnt_q <= cnt_q - 16'd1;
            end
          end
          SYNC_ONLINE: state_q <= SYNC_ONLINE;
          default:     state_q <= SYNC_IDLE;
        endcase
      end
    end

    // Online decode straight off the state register
    assign online_q[i] = (state_q == SYNC_ONLINE);
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

endmodule

`default_nettype wire

// File: lpif_pkg.sv
//////////////////////////////////////////////////
// Shared types for the logic-link data path
// Flit field vectors and the online sync FSM enum
// Modules pull these in with a wildcard import
//////////////////////////////////////////////////

`default_nettype none

`include "lpif_settings.svh"

package lpif_pkg;

  // Whole packed flit
  typedef logic [`LPIF_FLIT_W-1:0] flit_t;

  // One PHY lane word
  typedef logic [`LPIF_LANE_W-1:0] lane_t;

  // Flit fields with their own meaning
  typedef logic [3:0]  lpif_state_t;
  typedef logic [1:0]  protid_t;
  typedef logic [15:0] crc_t;

  // Debug status counter
  typedef logic [`LPIF_CNT_W-1:0] dbg_cnt_t;

  // Per-direction online sync FSM
  typedef enum logic [1:0] {
    SYNC_IDLE   = 2'd0,
    SYNC_COUNT  = 2'd1,
    SYNC_ONLINE = 2'd2
  } sync_state_e;

endpackage

`default_nettype wire

// File: lpif_properties.sv
//////////////////////////////////////////////////
// Concurrent checks on the x4 data path top
// Bound into every instance of the top level
//////////////////////////////////////////////////

`default_nettype none

module lpif_properties
  import lpif_pkg::*;
(
  input logic     clk_wr,
  input logic     rst_n,
  input logic     tx_online_delay,
  input logic     rx_online_delay,
  input lane_t    tx_phy0,
  input logic     dstrm_valid,
  input dbg_cnt_t tx_debug_status,
  input dbg_cnt_t rx_debug_status
);

  timeunit 1ns;
  timeprecision 100ps;

  // No downstream flit while rx is offline
  a_valid_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
    dstrm_valid |-> rx_online_delay)
    else $error("dstrm_valid high while rx_online_delay is low");

  // Strobe follows the online state through the lane register
  a_strobe_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy0[0] == $past(tx_online_delay))
    else $error("lane 0 strobe does not follow tx_online_delay");

  // Saturating counters only go up
  a_tx_cnt_up: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_debug_status >= $past(tx_debug_status))
    else $error("tx_debug_status decreased");

  a_rx_cnt_up: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_debug_status >= $past(rx_debug_status))
    else $error("rx_debug_status decreased");

endmodule

bind lpif_txrx_x4_top lpif_properties u_props (
  .clk_wr          (clk_wr),
  .rst_n           (rst_n),
  .tx_online_delay (tx_online_delay),
  .rx_online_delay (rx_online_delay),
  .tx_phy0         (tx_phy0),
  .dstrm_valid     (dstrm_valid),
  .tx_debug_status (tx_debug_status),
  .rx_debug_status (rx_debug_status)
);

`default_nettype wire

// File: lpif_rx_flit.sv
//////////////////////////////////////////////////
// Rx stage 2
// Registers the rebuilt flit and splits it into
// the downstream fields. Outputs read zero while
// rx is offline
//////////////////////////////////////////////////

`default_nettype none

`include "lpif_settings.svh"

module lpif_rx_flit
  import lpif_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,
  input  logic                    rx_online_delay,
  input  flit_t                   rx_flit,
  input  logic                    rx_flit_valid,
  output lpif_state_t             dstrm_state,
  output protid_t                 dstrm_protid,
  output logic [`LPIF_DATA_W-1:0] dstrm_data,
  output logic                    dstrm_dvalid,
  output crc_t                    dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid
);

  flit_t                   flit_q;
  logic                    valid_q;
  lpif_state_t             f_state;
  protid_t                 f_protid;
  logic [`LPIF_DATA_W-1:0] f_data;
  logic                    f_dvalid;
  crc_t                    f_crc;
  logic                    f_crc_valid;

  always_ff @(posedge clk_wr) begin
    flit_q <= rx_flit;
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rx_flit_valid;
    end
  end

  // Field split, valid field already folded into valid_q
  assign {f_state, f_protid, f_data, f_dvalid, f_crc, f_crc_valid} =
         flit_q[`LPIF_FLIT_W-1:1];

  // Offline forces every output low
  assign dstrm_state     = rx_online_delay ? f_state     : '0;
  assign dstrm_protid    = rx_online_delay ? f_protid    : '0;
  assign dstrm_data      = rx_online_delay ? f_data      : '0;
  assign dstrm_dvalid    = rx_online_delay & f_dvalid;
  assign dstrm_crc       = rx_online_delay ? f_crc       : '0;
  assign dstrm_crc_valid = rx_online_delay & f_crc_valid;
  assign dstrm_valid     = rx_online_delay & valid_q;

endmodule

`default_nettype wire

// File: lpif_rx_lanes.sv
//////////////////////////////////////////////////
// Rx stage 1
// Registers the PHY lanes and rebuilds the flit
// Flit valid needs strobe and marker both present
// Counts online words with either bit missing
//////////////////////////////////////////////////

`default_nettype none

`include "lpif_settings.svh"

module lpif_rx_lanes
  import lpif_pkg::*;
(
  input  logic     clk_wr,
  input  logic     rst_n,
  input  logic     rx_online_delay,
  input  lane_t    rx_phy0,
  input  lane_t    rx_phy1,
  input  lane_t    rx_phy2,
  input  lane_t    rx_phy3,
  output flit_t    rx_flit,
  output logic     rx_flit_valid,
  output dbg_cnt_t rx_debug_status
);

  localparam int PAY_W = `LPIF_LANE_W - 1;
  localparam int PAD_W = `LPIF_LANES * PAY_W;

  lane_t            lanes [`LPIF_LANES];
  logic [PAD_W-1:0] pad;
  logic             strobe;
  logic             marker;
  logic             word_ok;

  assign lanes[0] = rx_phy0;
  assign lanes[1] = rx_phy1;
  assign lanes[2] = rx_phy2;
  assign lanes[3] = rx_phy3;

  // Gather lane payloads back into flit order
  always_comb begin
    for (int k = 0; k < `LPIF_LANES; k++) begin
      pad[k*PAY_W +: PAY_W] = lanes[k][`LPIF_LANE_W-1:1];
    end
  end

  assign strobe  = lanes[0][0];
  assign marker  = lanes[`LPIF_LANES-1][0];
  assign word_ok = strobe & marker;

  //////////////////////////////////////////////////
  // Flit register, padding bits dropped here
  always_ff @(posedge clk_wr) begin
    rx_flit <= pad[`LPIF_FLIT_W-1:0];
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_flit_valid   <= 1'b0;
      rx_debug_status <= '0;
    end else begin
      // Flit's own valid field at bit 0
      rx_flit_valid <= word_ok & pad[0];
      // Framing error count, saturating
      if (rx_online_delay && !word_ok && (rx_debug_status != '1)) begin
        rx_debug_status <= rx_debug_status + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: lpif_settings.svh
//////////////////////////////////////////////////
// Sizing macros for the x4 logic-link data path
// Include in any file that needs a lane, flit or
// counter width
//////////////////////////////////////////////////

`ifndef LPIF_SETTINGS_SVH
`define LPIF_SETTINGS_SVH

// PHY lane count
`define LPIF_LANES 4

// Bits per lane word, bit 0 reserved for strobe or marker
`define LPIF_LANE_W 24

// User payload width
`define LPIF_DATA_W 64

// Packed flit width
// state 4 + protid 2 + data + dvalid 1 + crc 16 + crc_valid 1 + valid 1
`define LPIF_FLIT_W 89

// Debug status counters
`define LPIF_CNT_W 32

`endif

// File: lpif_tx_flit.sv
//////////////////////////////////////////////////
// Tx stage 1
// Registers the upstream fields as one packed flit
// and counts the flits accepted while online
//////////////////////////////////////////////////

`default_nettype none

`include "lpif_settings.svh"

module lpif_tx_flit
  import lpif_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,
  input  logic                    tx_online_delay,
  input  lpif_state_t             ustrm_state,
  input  protid_t                 ustrm_protid,
  input  logic [`LPIF_DATA_W-1:0] ustrm_data,
  input  logic                    ustrm_dvalid,
  input  crc_t                    ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,
  output flit_t                   tx_flit,
  output logic                    tx_flit_valid,
  output dbg_cnt_t                tx_debug_status
);

  // Upstream valid only counts once the link is up
  logic accept;

  assign accept = ustrm_valid & tx_online_delay;

  // Flit word, state at the top and valid at bit 0
  always_ff @(posedge clk_wr) begin
    tx_flit <= {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                ustrm_crc, ustrm_crc_valid, accept};
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_flit_valid   <= 1'b0;
      tx_debug_status <= '0;
    end else begin
      tx_flit_valid <= accept;
      // Sent flit count, sticks at all ones
      if (accept && (tx_debug_status != '1)) begin
        tx_debug_status <= tx_debug_status + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: lpif_tx_lanes.sv
//////////////////////////////////////////////////
// Tx stage 2
// Stripes the flit over the PHY lanes with strobe
// on lane 0 bit 0 and marker on the last lane
// Lanes are all zero while tx is offline
//////////////////////////////////////////////////

`default_nettype none

`include "lpif_settings.svh"

module lpif_tx_lanes
  import lpif_pkg::*;
(
  input  logic  clk_wr,
  input  logic  rst_n,
  input  logic  tx_online_delay,
  input  flit_t tx_flit,
  input  logic  tx_flit_valid,
  output lane_t tx_phy0,
  output lane_t tx_phy1,
  output lane_t tx_phy2,
  output lane_t tx_phy3
);

  // Payload bits per lane above the control bit
  localparam int PAY_W = `LPIF_LANE_W - 1;
  localparam int PAD_W = `LPIF_LANES * PAY_W;

  logic [PAD_W-1:0] pad;
  lane_t            lane_d [`LPIF_LANES];
  lane_t            lane_q [`LPIF_LANES];

  always_comb begin
    // Zero payload when no flit, top bits are padding
    pad = '0;
    if (tx_flit_valid) begin
      pad[`LPIF_FLIT_W-1:0] = tx_flit;
    end
    for (int k = 0; k < `LPIF_LANES; k++) begin
      lane_d[k] = {pad[k*PAY_W +: PAY_W], 1'b0};
      // Strobe on first lane, marker on last lane
      if ((k == 0) || (k == `LPIF_LANES - 1)) begin
        lane_d[k][0] = 1'b1;
      end
      if (!tx_online_delay) begin
        lane_d[k] = '0;
      end
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < `LPIF_LANES; k++) begin
        lane_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `LPIF_LANES; k++) begin
        lane_q[k] <= lane_d[k];
      end
    end
  end

  assign tx_phy0 = lane_q[0];
  assign tx_phy1 = lane_q[1];
  assign tx_phy2 = lane_q[2];
  assign tx_phy3 = lane_q[3];

endmodule

`default_nettype wire

// File: lpif_txrx_x4_top.sv
//////////////////////////////////////////////////
// Top level of the x4 logic-link data path
// Upstream flit in, four PHY lanes out and back in,
// downstream flit out. Instances and wires only
//////////////////////////////////////////////////

`default_nettype none

`include "lpif_settings.svh"

module lpif_txrx_x4_top
  import lpif_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,
  // Link control
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic [15:0]             delay_x_value,
  input  logic [15:0]             delay_y_value,
  // PHY lanes
  output lane_t                   tx_phy0,
  output lane_t                   tx_phy1,
  output lane_t                   tx_phy2,
  output lane_t                   tx_phy3,
  input  lane_t                   rx_phy0,
  input  lane_t                   rx_phy1,
  input  lane_t                   rx_phy2,
  input  lane_t                   rx_phy3,
  // Upstream channel
  input  lpif_state_t             ustrm_state,
  input  protid_t                 ustrm_protid,
  input  logic [`LPIF_DATA_W-1:0] ustrm_data,
  input  logic                    ustrm_dvalid,
  input  crc_t                    ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,
  // Downstream channel
  output lpif_state_t             dstrm_state,
  output protid_t                 dstrm_protid,
  output logic [`LPIF_DATA_W-1:0] dstrm_data,
  output logic                    dstrm_dvalid,
  output crc_t                    dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid,
  // Debug counters
  output dbg_cnt_t                tx_debug_status,
  output dbg_cnt_t                rx_debug_status
);

  logic  tx_online_delay;
  logic  rx_online_delay;
  flit_t tx_flit;
  logic  tx_flit_valid;
  flit_t rx_flit;
  logic  rx_flit_valid;

  //////////////////////////////////////////////////
  // Online sync
  lpif_online_sync u_sync (
    .clk_wr, .rst_n, .tx_online, .rx_online, .delay_x_value, .delay_y_value,
    .tx_online_delay, .rx_online_delay
  );

  //////////////////////////////////////////////////
  // Tx path, flit register then lane register
  lpif_tx_flit u_tx_flit (
    .clk_wr, .rst_n, .tx_online_delay,
    .ustrm_state, .ustrm_protid, .ustrm_data, .ustrm_dvalid,
    .ustrm_crc, .ustrm_crc_valid, .ustrm_valid,
    .tx_flit, .tx_flit_valid, .tx_debug_status
  );

  lpif_tx_lanes u_tx_lanes (
    .clk_wr, .rst_n, .tx_online_delay, .tx_flit, .tx_flit_valid,
    .tx_phy0, .tx_phy1, .tx_phy2, .tx_phy3
  );

  //////////////////////////////////////////////////
  // Rx path, lane register then field register
  lpif_rx_lanes u_rx_lanes (
    .clk_wr, .rst_n, .rx_online_delay,
    .rx_phy0, .rx_phy1, .rx_phy2, .rx_phy3,
    .rx_flit, .rx_flit_valid, .rx_debug_status
  );

  lpif_rx_flit u_rx_flit (
    .clk_wr, .rst_n, .rx_online_delay, .rx_flit, .rx_flit_valid,
    .dstrm_state, .dstrm_protid, .dstrm_data, .dstrm_dvalid,
    .dstrm_crc, .dstrm_crc_valid, .dstrm_valid
  );

endmodule

`default_nettype wire

// File: lpif_vectors.txt
// columns: state protid data dvalid crc crc_valid corrupt
// one flit per line, every field in hex, corrupt 1 clears the lane 0 strobe
1 0 0123456789abcdef 1 a5c3 1 0
2 1 fedcba9876543210 1 5a3c 1 0
3 2 ffffffffffffffff 0 ffff 0 0
4 3 0000000000000000 1 0000 1 0
5 0 deadbeefcafef00d 1 1234 1 0
6 1 8000000000000001 0 8001 1 0
7 2 0f0f0f0f0f0f0f0f 1 f0f0 0 1
8 3 aaaaaaaaaaaaaaaa 1 5555 1 0
9 0 5555555555555555 0 aaaa 1 0
a 1 1122334455667788 1 9988 0 0
b 2 99aabbccddeeff00 1 7766 1 0
c 3 7fffffffffffffff 0 3c3c 1 1
d 0 0000000100000002 1 0102 1 0
e 1 13579bdf2468ace0 1 fedc 0 0
f 2 c001d00dfeedface 0 4321 1 0
0 3 3141592653589793 1 2718 1 0
1 0 0000ffff0000ffff 1 abcd 1 1
2 1 ffff0000ffff0000 0 dcba 0 0
3 2 6db6db6db6db6db6 1 0f0f 1 0
4 3 a5a5a5a55a5a5a5a 1 beef 1 0

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lpif -f sim.f \
  && ./obj_dir/Vtb_lpif > sim.log 2>&1 \
  || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx ">>> PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+.
lpif_pkg.sv
lpif_online_sync.sv
lpif_tx_flit.sv
lpif_tx_lanes.sv
lpif_rx_lanes.sv
lpif_rx_flit.sv
lpif_txrx_x4_top.sv
lpif_properties.sv
tb_clock.sv
tb_lpif.sv

// File: tb_clock.sv
//////////////////////////////////////////////////
// Testbench clock and reset source
// 10 ns clk_wr, rst_n held low for 8 rising edges
//////////////////////////////////////////////////

`default_nettype none

module tb_clock (
  output logic clk_wr,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 8;

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  // Release just after an edge so the DUT sees a clean deassert
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_lpif.sv
//////////////////////////////////////////////////
// Testbench for the x4 logic-link data path
// Loops the PHY lanes back through a corrupt mask,
// plays the flits of lpif_vectors.txt and checks
// the downstream flits, the online delay and the
// debug counters. Run it through run_sim.sh
//////////////////////////////////////////////////

`default_nettype none

`include "lpif_settings.svh"

module tb_lpif
  import lpif_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_VEC  = 20;
  localparam int VEC_COLS = 7;
  localparam int WAIT_MAX = 100;
  localparam int LOOP_LAT = 4;
  localparam int DELAY_X  = 7;
  localparam int DELAY_Y  = 5;

  logic                    clk_wr;
  logic                    rst_n;
  logic                    tx_online;
  logic                    rx_online;
  logic [15:0]             delay_x_value;
  logic [15:0]             delay_y_value;
  lane_t                   tx_phy0;
  lane_t                   tx_phy1;
  lane_t                   tx_phy2;
  lane_t                   tx_phy3;
  lane_t                   rx_phy0;
  lane_t                   rx_phy1;
  lane_t                   rx_phy2;
  lane_t                   rx_phy3;
  lpif_state_t             ustrm_state;
  protid_t                 ustrm_protid;
  logic [`LPIF_DATA_W-1:0] ustrm_data;
  logic                    ustrm_dvalid;
  crc_t                    ustrm_crc;
  logic                    ustrm_crc_valid;
  logic                    ustrm_valid;
  lpif_state_t             dstrm_state;
  protid_t                 dstrm_protid;
  logic [`LPIF_DATA_W-1:0] dstrm_data;
  logic                    dstrm_dvalid;
  crc_t                    dstrm_crc;
  logic                    dstrm_crc_valid;
  logic                    dstrm_valid;
  dbg_cnt_t                tx_debug_status;
  dbg_cnt_t                rx_debug_status;

  // Seven hex words per flit line
  logic [63:0] vec_mem [NUM_VEC*VEC_COLS];
  // Expected fields from state down to crc_valid and their due cycles
  logic [87:0] exp_q [$];
  int          due_q [$];

  int     cyc;
  int     errors;
  int     tests_failed;
  int     sent_cnt;
  int     corrupt_cnt;
  integer seed;
  logic   corrupt_drv;
  logic   corrupt_d1;
  logic   corrupt_d2;

  tb_clock u_clock (.clk_wr, .rst_n);

  lpif_txrx_x4_top DUT (
    .clk_wr, .rst_n, .tx_online, .rx_online, .delay_x_value, .delay_y_value,
    .tx_phy0, .tx_phy1, .tx_phy2, .tx_phy3,
    .rx_phy0, .rx_phy1, .rx_phy2, .rx_phy3,
    .ustrm_state, .ustrm_protid, .ustrm_data, .ustrm_dvalid,
    .ustrm_crc, .ustrm_crc_valid, .ustrm_valid,
    .dstrm_state, .dstrm_protid, .dstrm_data, .dstrm_dvalid,
    .dstrm_crc, .dstrm_crc_valid, .dstrm_valid,
    .tx_debug_status, .rx_debug_status
  );

  //////////////////////////////////////////////////
  // Lane loopback
  // Corrupt flag follows the flit to the lane stage
  assign rx_phy0 = {tx_phy0[`LPIF_LANE_W-1:1], tx_phy0[0] & ~corrupt_d2};
  assign rx_phy1 = tx_phy1;
  assign rx_phy2 = tx_phy2;
  assign rx_phy3 = tx_phy3;

  always @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      cyc        <= 0;
      corrupt_d1 <= 1'b0;
      corrupt_d2 <= 1'b0;
    end else begin
      cyc        <= cyc + 1;
      corrupt_d1 <= corrupt_drv;
      corrupt_d2 <= corrupt_d1;
    end
  end

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] want);
    if (got !== want) begin
      $display("** Error at %0d ns: %s got %h expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic note_fail(input string what);
    $display("** Error at %0d ns: %s", $time, what);
    errors++;
  endtask

  // Inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  task automatic drive_idle();
    ustrm_valid = 1'b0;
    corrupt_drv = 1'b0;
  endtask

  task automatic drive_flit(input int idx, input bit expect_out);
    int base;
    base            = idx * VEC_COLS;
    ustrm_state     = vec_mem[base][3:0];
    ustrm_protid    = vec_mem[base+1][1:0];
    ustrm_data      = vec_mem[base+2];
    ustrm_dvalid    = vec_mem[base+3][0];
    ustrm_crc       = vec_mem[base+4][15:0];
    ustrm_crc_valid = vec_mem[base+5][0];
    ustrm_valid     = 1'b1;
    corrupt_drv     = expect_out & vec_mem[base+6][0];
    if (expect_out) begin
      sent_cnt++;
      if (vec_mem[base+6][0]) begin
        corrupt_cnt++;
      end else begin
        exp_q.push_back({vec_mem[base][3:0], vec_mem[base+1][1:0], vec_mem[base+2],
                         vec_mem[base+3][0], vec_mem[base+4][15:0], vec_mem[base+5][0]});
        due_q.push_back(cyc + LOOP_LAT);
      end
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (due_q.size() > 0 && waited < WAIT_MAX) begin
      next_cycle();
      waited++;
    end
    if (due_q.size() > 0) begin
      note_fail("expected flits never showed up on dstrm");
    end
  endtask

  task automatic end_test(input int num, input string name, input int err_before);
    int n;
    n = errors - err_before;
    if (n == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, n);
      tests_failed++;
    end
  endtask

  //////////////////////////////////////////////////
  // Downstream monitor sampled mid-cycle
  always @(negedge clk_wr) begin : monitor
    logic [87:0] want;
    int          due;
    if (rst_n) begin
      if (dstrm_valid) begin
        if (due_q.size() == 0) begin
          note_fail("dstrm_valid high with no flit expected");
        end else begin
          want = exp_q.pop_front();
          due  = due_q.pop_front();
          check_val("arrival_cycle", 64'(cyc), 64'(due));
          check_val("dstrm_state", 64'(dstrm_state), 64'(want[87:84]));
          check_val("dstrm_protid", 64'(dstrm_protid), 64'(want[83:82]));
          check_val("dstrm_data", dstrm_data, want[81:18]);
          check_val("dstrm_dvalid", 64'(dstrm_dvalid), 64'(want[17]));
          check_val("dstrm_crc", 64'(dstrm_crc), 64'(want[16:1]));
          check_val("dstrm_crc_valid", 64'(dstrm_crc_valid), 64'(want[0]));
        end
      end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
        // Drop a missing due flit so later ones still line up
        note_fail("expected flit did not appear on dstrm");
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  initial begin : main
    int       err0;
    int       start;
    int       first;
    int       gap;
    int       waited;
    dbg_cnt_t tx_cnt_hold;

    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = 16'(DELAY_X);
    delay_y_value   = 16'(DELAY_Y);
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    corrupt_drv     = 1'b0;
    seed            = 32'h31d8_24c9;
    errors          = 0;
    tests_failed    = 0;
    sent_cnt        = 0;
    corrupt_cnt     = 0;
    $readmemh("lpif_vectors.txt", vec_mem);

    // Test 1 reset values with both directions offline
    err0   = errors;
    waited = 0;
    while (!rst_n && waited < WAIT_MAX) begin
      @(posedge clk_wr);
      waited++;
    end
    if (!rst_n) begin
      note_fail("reset was never released");
    end
    repeat (2) @(negedge clk_wr);
    check_val("tx_phy0", 64'(tx_phy0), 64'd0);
    check_val("tx_phy1", 64'(tx_phy1), 64'd0);
    check_val("tx_phy2", 64'(tx_phy2), 64'd0);
    check_val("tx_phy3", 64'(tx_phy3), 64'd0);
    check_val("dstrm_state", 64'(dstrm_state), 64'd0);
    check_val("dstrm_protid", 64'(dstrm_protid), 64'd0);
    check_val("dstrm_data", dstrm_data, 64'd0);
    check_val("dstrm_dvalid", 64'(dstrm_dvalid), 64'd0);
    check_val("dstrm_crc", 64'(dstrm_crc), 64'd0);
    check_val("dstrm_crc_valid", 64'(dstrm_crc_valid), 64'd0);
    check_val("dstrm_valid", 64'(dstrm_valid), 64'd0);
    check_val("tx_debug_status", 64'(tx_debug_status), 64'd0);
    check_val("rx_debug_status", 64'(rx_debug_status), 64'd0);
    end_test(1, "reset", err0);

    // Test 2 online delay
    // Rx uses the longer delay so it never sees the strobe-less lanes
    err0 = errors;
    next_cycle();
    tx_online = 1'b1;
    rx_online = 1'b1;
    start     = cyc;
    first     = -1;
    waited    = 0;
    while (first < 0 && waited < WAIT_MAX) begin
      @(negedge clk_wr);
      waited++;
      if (tx_phy0[0]) begin
        first = cyc;
      end else if ({tx_phy0, tx_phy1, tx_phy2, tx_phy3} != '0) begin
        note_fail("tx lanes not all zero before the link came up");
      end
    end
    if (first < 0) begin
      note_fail("strobe on lane 0 never rose");
    end else begin
      // Sample edge plus delay plus one plus the lane register
      check_val("strobe_rise_cycle", 64'(first), 64'(start + 1 + DELAY_Y + 2));
    end
    end_test(2, "online delay", err0);

    // Test 3 loopback
    // First four flits back to back and random gaps after that
    err0 = errors;
    for (int v = 0; v < NUM_VEC; v++) begin
      next_cycle();
      drive_flit(v, 1'b1);
      gap = (v < 4) ? 0 : ($random(seed) & 3);
      for (int g = 0; g < gap; g++) begin
        next_cycle();
        drive_idle();
      end
    end
    next_cycle();
    drive_idle();
    wait_drained();
    end_test(3, "loopback", err0);

    // Test 4 corruption and counters
    err0 = errors;
    repeat (2) next_cycle();
    @(negedge clk_wr);
    if (corrupt_cnt == 0) begin
      note_fail("vector file holds no corrupt flit");
    end
    check_val("rx_debug_status", 64'(rx_debug_status), 64'(corrupt_cnt));
    check_val("tx_debug_status", 64'(tx_debug_status), 64'(sent_cnt));
    end_test(4, "corruption", err0);

    // Test 5 tx offline while rx stays up
    err0        = errors;
    tx_cnt_hold = tx_debug_status;
    next_cycle();
    tx_online = 1'b0;
    waited    = 0;
    while (tx_phy0[0] && waited < WAIT_MAX) begin
      @(negedge clk_wr);
      waited++;
    end
    if (tx_phy0[0]) begin
      note_fail("strobe on lane 0 stayed high after tx went offline");
    end
    for (int v = 0; v < 4; v++) begin
      next_cycle();
      drive_flit(v, 1'b0);
    end
    next_cycle();
    drive_idle();
    repeat (LOOP_LAT + 4) next_cycle();
    check_val("tx_debug_status", 64'(tx_debug_status), 64'(tx_cnt_hold));
    end_test(5, "offline", err0);

    $display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
